// File: rtl/cpuPkg.sv
package cpuPkg;

    localparam int wordBits = 32;
    localparam int memWords = 512;

    // instruction field positions
    localparam int opLsb = 27;
    localparam int raLsb = 23;
    localparam int rbLsb = 19;
    localparam int rcLsb = 15;
    localparam int condLsb = 19;
    localparam int constMsb = 18;

    typedef logic [wordBits-1:0] dataWord;
    typedef logic [$clog2(memWords)-1:0] memAddr;
    typedef logic [3:0] regIndex;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluShr, aluShl, aluIncPc
    } aluOp;

    typedef enum logic [4:0] {
        opLd   = 5'b00000,
        opLdi  = 5'b00001,
        opSt   = 5'b00010,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opShr  = 5'b00111,
        opShl  = 5'b01000,
        opAddi = 5'b01001,
        opAndi = 5'b01010,
        opOri  = 5'b01011,
        opBr   = 5'b10010,
        opIn   = 5'b10110,
        opOut  = 5'b10111,
        opHalt = 5'b11011
    } opcode;

    typedef enum logic [3:0] {
        t0, t1, t2, t3, t4, t5, t6, t7, halted
    } tState;

    // the one block that drives the bus this cycle
    typedef enum logic [2:0] {
        regOut, pcOut, mdrOut, zOut, inportOut, cOut
    } busSource;

    typedef struct packed {
        busSource busSel;
        logic marIn;
        logic zIn;
        logic pcIn;
        logic mdrIn;
        logic irIn;
        logic yIn;
        logic conIn;
        logic outportIn;
        logic gra;
        logic grb;
        logic grc;
        logic rIn;
        logic baOut;
        aluOp alu;
        logic memRead;
        logic memWrite;
    } ctrlSignals;

endpackage

// File: rtl/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  cpuPkg::aluOp    op,
    input  cpuPkg::dataWord a,
    input  cpuPkg::dataWord b,
    output cpuPkg::dataWord result
);
    import cpuPkg::*;

    logic [$clog2(wordBits)-1:0] shiftCount;

    // only the low bits of b count for a shift
    assign shiftCount = b[$clog2(wordBits)-1:0];

    always_comb begin
        case (op)
            aluAdd: begin
                result = a + b;
            end
            aluSub: begin
                result = a - b;
            end
            aluAnd: begin
                result = a & b;
            end
            aluOr: begin
                result = a | b;
            end
            aluShr: begin
                result = a >> shiftCount;
            end
            aluShl: begin
                result = a << shiftCount;
            end
            aluIncPc: begin
                // the PC arrives on the bus side
                result = b + 1'b1;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: rtl/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::dataWord ir,
    input  logic            gra,
    input  logic            grb,
    input  logic            grc,
    input  logic            rIn,
    input  logic            baOut,
    input  cpuPkg::dataWord busIn,
    output cpuPkg::dataWord regValue
);
    import cpuPkg::*;

    dataWord regs [2**$bits(regIndex)];
    regIndex sel;

    // field select, Ra wins over Rb over Rc
    always_comb begin
        if (gra) begin
            sel = ir[raLsb +: $bits(regIndex)];
        end else if (grb) begin
            sel = ir[rbLsb +: $bits(regIndex)];
        end else if (grc) begin
            sel = ir[rcLsb +: $bits(regIndex)];
        end else begin
            sel = '0;
        end
    end

    // R0 as a base register reads as zero
    assign regValue = (baOut && sel == '0) ? '0 : regs[sel];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**$bits(regIndex); i++) begin
                regs[i] <= '0;
            end
        end else if (rIn) begin
            regs[sel] <= busIn;
        end
    end

endmodule

// File: rtl/dataPath.sv
`timescale 1ns/1ps

module dataPath (
    input  logic               clk,
    input  logic               reset,
    input  cpuPkg::ctrlSignals ctrl,
    input  cpuPkg::dataWord    readData,
    input  cpuPkg::dataWord    inPort,
    output cpuPkg::dataWord    ir,
    output logic               conFlag,
    output cpuPkg::memAddr     marValue,
    output cpuPkg::dataWord    mdrValue,
    output cpuPkg::dataWord    outPort
);
    import cpuPkg::*;

    dataWord bus;
    dataWord pc;
    dataWord mdr;
    dataWord y;
    dataWord z;
    dataWord regValue;
    dataWord aluResult;
    dataWord constC;
    memAddr  mar;
    logic    memReadQ;
    logic    condMet;

    assign constC = {{(wordBits - constMsb - 1){ir[constMsb]}}, ir[constMsb:0]};

    always_comb begin
        case (ctrl.busSel)
            regOut:    bus = regValue;
            pcOut:     bus = pc;
            mdrOut:    bus = mdr;
            zOut:      bus = z;
            inportOut: bus = inPort;
            cOut:      bus = constC;
            default:   bus = '0;
        endcase
    end

    registerFile registerFile_inst (
        .clk      (clk),
        .reset    (reset),
        .ir       (ir),
        .gra      (ctrl.gra),
        .grb      (ctrl.grb),
        .grc      (ctrl.grc),
        .rIn      (ctrl.rIn),
        .baOut    (ctrl.baOut),
        .busIn    (bus),
        .regValue (regValue)
    );

    aluUnit aluUnit_inst (
        .op     (ctrl.alu),
        .a      (y),
        .b      (bus),
        .result (aluResult)
    );

    // branch test of Ra, which is on the bus at T3
    always_comb begin
        case (ir[condLsb +: 2])
            2'b00:   condMet = (bus == '0);
            2'b01:   condMet = (bus != '0);
            2'b10:   condMet = !bus[wordBits-1];
            default: condMet = bus[wordBits-1];
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
            ir <= '0;
            outPort <= '0;
            conFlag <= 1'b0;
            memReadQ <= 1'b0;
        end else begin
            memReadQ <= ctrl.memRead;
            if (ctrl.pcIn) begin
                pc <= bus;
            end
            if (ctrl.irIn) begin
                ir <= bus;
            end
            if (ctrl.outportIn) begin
                outPort <= bus;
            end
            if (ctrl.conIn) begin
                conFlag <= condMet;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.marIn) begin
            mar <= bus[$bits(memAddr)-1:0];
        end
        // a read issued last cycle has its word ready now
        if (ctrl.mdrIn) begin
            mdr <= memReadQ ? readData : bus;
        end
        if (ctrl.yIn) begin
            y <= bus;
        end
        if (ctrl.zIn) begin
            z <= aluResult;
        end
    end

    // memory sees the new address in the same cycle MAR loads it
    assign marValue = ctrl.marIn ? bus[$bits(memAddr)-1:0] : mar;
    assign mdrValue = mdr;

endmodule

// File: rtl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic               clk,
    input  logic               reset,
    input  logic               stop,
    input  cpuPkg::dataWord    ir,
    input  logic               conFlag,
    output cpuPkg::ctrlSignals ctrl,
    output logic               run
);
    import cpuPkg::*;

    tState state;
    tState nextState;
    opcode op;
    aluOp  aluFn;
    logic  isAluReg;
    logic  isAluImm;
    logic  isLoadStore;
    logic  brTaken;

    assign op = opcode'(ir[opLsb +: 5]);
    assign isAluReg = op inside {opAdd, opSub, opAnd, opOr, opShr, opShl};
    assign isAluImm = op inside {opAddi, opAndi, opOri};
    assign isLoadStore = op inside {opLd, opLdi, opSt};
    assign brTaken = (op == opBr) && conFlag;
    assign run = (state != halted);

    // function used in the T4 step, address arithmetic is an add
    always_comb begin
        case (op)
            opSub:          aluFn = aluSub;
            opAnd, opAndi:  aluFn = aluAnd;
            opOr, opOri:    aluFn = aluOr;
            opShr:          aluFn = aluShr;
            opShl:          aluFn = aluShl;
            default:        aluFn = aluAdd;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= t0;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            t0: nextState = stop ? t0 : t1;
            t1: nextState = t2;
            t2: nextState = t3;
            t3: begin
                if (op == opHalt) begin
                    nextState = halted;
                end else if (isAluReg || isAluImm || isLoadStore || op == opBr) begin
                    nextState = t4;
                end else begin
                    // in, out and unknown opcodes finish here
                    nextState = t0;
                end
            end
            t4: nextState = t5;
            t5: nextState = (isAluReg || isAluImm) ? t0 : t6;
            t6: nextState = (op == opBr) ? t0 : t7;
            t7: nextState = t0;
            default: nextState = halted;
        endcase
    end

    always_comb begin
        ctrl = '0;
        ctrl.busSel = pcOut;
        ctrl.alu = aluAdd;
        case (state)
            t0: begin
                if (!stop) begin
                    ctrl.busSel = pcOut;
                    ctrl.marIn = 1'b1;
                    ctrl.alu = aluIncPc;
                    ctrl.zIn = 1'b1;
                    ctrl.memRead = 1'b1;
                end
            end
            t1: begin
                ctrl.busSel = zOut;
                ctrl.pcIn = 1'b1;
                ctrl.mdrIn = 1'b1;
            end
            t2: begin
                ctrl.busSel = mdrOut;
                ctrl.irIn = 1'b1;
            end
            t3: begin
                if (isAluReg || isAluImm || isLoadStore) begin
                    ctrl.busSel = regOut;
                    ctrl.grb = 1'b1;
                    ctrl.baOut = isLoadStore;
                    ctrl.yIn = 1'b1;
                end else if (op == opBr) begin
                    ctrl.busSel = regOut;
                    ctrl.gra = 1'b1;
                    ctrl.conIn = 1'b1;
                end else if (op == opIn) begin
                    ctrl.busSel = inportOut;
                    ctrl.gra = 1'b1;
                    ctrl.rIn = 1'b1;
                end else if (op == opOut) begin
                    ctrl.busSel = regOut;
                    ctrl.gra = 1'b1;
                    ctrl.outportIn = 1'b1;
                end
            end
            t4: begin
                if (isAluReg) begin
                    ctrl.busSel = regOut;
                    ctrl.grc = 1'b1;
                    ctrl.alu = aluFn;
                    ctrl.zIn = 1'b1;
                end else if (isAluImm || isLoadStore) begin
                    ctrl.busSel = cOut;
                    ctrl.alu = aluFn;
                    ctrl.zIn = 1'b1;
                end else if (brTaken) begin
                    ctrl.busSel = pcOut;
                    ctrl.yIn = 1'b1;
                end
            end
            t5: begin
                if (isAluReg || isAluImm || op == opLdi) begin
                    ctrl.busSel = zOut;
                    ctrl.gra = 1'b1;
                    ctrl.rIn = 1'b1;
                end else if (op == opLd || op == opSt) begin
                    // ld starts its read in the same cycle MAR loads
                    ctrl.busSel = zOut;
                    ctrl.marIn = 1'b1;
                    ctrl.memRead = (op == opLd);
                end else if (brTaken) begin
                    ctrl.busSel = cOut;
                    ctrl.alu = aluAdd;
                    ctrl.zIn = 1'b1;
                end
            end
            t6: begin
                if (op == opLd) begin
                    ctrl.mdrIn = 1'b1;
                end else if (op == opSt) begin
                    ctrl.busSel = regOut;
                    ctrl.gra = 1'b1;
                    ctrl.mdrIn = 1'b1;
                end else if (brTaken) begin
                    ctrl.busSel = zOut;
                    ctrl.pcIn = 1'b1;
                end
            end
            t7: begin
                if (op == opLd) begin
                    ctrl.busSel = mdrOut;
                    ctrl.gra = 1'b1;
                    ctrl.rIn = 1'b1;
                end else if (op == opSt) begin
                    ctrl.memWrite = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // once run has fallen nothing may reach memory
    assert property (@(posedge clk) disable iff (reset) !run |=> !ctrl.memWrite)
        else $error("memory write after halt");

    // only reset leaves the halted state
    assert property (@(posedge clk) disable iff (reset) state == halted |=> state == halted)
        else $error("sequencer left halted without reset");

endmodule

// File: rtl/memory512x32.sv
`timescale 1ns/1ps

module memory512x32 (
    input  logic            clk,
    input  cpuPkg::memAddr  addr,
    input  cpuPkg::dataWord writeData,
    input  logic            memRead,
    input  logic            memWrite,
    input  logic            loadWrite,
    input  cpuPkg::memAddr  loadAddr,
    input  cpuPkg::dataWord loadData,
    output cpuPkg::dataWord readData
);
    import cpuPkg::*;

    dataWord mem [memWords];

    always_ff @(posedge clk) begin
        // the load port beats the CPU port
        if (loadWrite) begin
            mem[loadAddr] <= loadData;
        end else if (memWrite) begin
            mem[addr] <= writeData;
        end
        if (memRead) begin
            readData <= mem[addr];
        end
    end

endmodule

// File: rtl/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
    input  logic            clk,
    input  logic            reset,
    input  logic            stop,
    output logic            run,
    input  cpuPkg::dataWord inPort,
    output cpuPkg::dataWord outPort,
    input  logic            loadWrite,
    input  cpuPkg::memAddr  loadAddr,
    input  cpuPkg::dataWord loadData
);
    import cpuPkg::*;

    ctrlSignals ctrl;
    dataWord    ir;
    dataWord    mdrValue;
    dataWord    readData;
    memAddr     marValue;
    logic       conFlag;

    controlUnit controlUnit_inst (
        .clk     (clk),
        .reset   (reset),
        .stop    (stop),
        .ir      (ir),
        .conFlag (conFlag),
        .ctrl    (ctrl),
        .run     (run)
    );

    dataPath dataPath_inst (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .readData (readData),
        .inPort   (inPort),
        .ir       (ir),
        .conFlag  (conFlag),
        .marValue (marValue),
        .mdrValue (mdrValue),
        .outPort  (outPort)
    );

    memory512x32 memory512x32_inst (
        .clk       (clk),
        .addr      (marValue),
        .writeData (mdrValue),
        .memRead   (ctrl.memRead),
        .memWrite  (ctrl.memWrite),
        .loadWrite (loadWrite),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .readData  (readData)
    );

endmodule

// File: dv/cpuTopTb.sv
`timescale 1ns/1ps

module cpuTopTb;
    import cpuPkg::*;

    localparam int numTests = 5;
    localparam int cyclesPerTest = 2000;

    logic        clk;
    logic        reset;
    logic        stop;
    logic        run;
    dataWord     inPort;
    dataWord     outPort;
    logic        loadWrite;
    memAddr      loadAddr;
    dataWord     loadData;

    dataWord     prog [$];
    logic [31:0] lfsrState;
    int          checkCount;
    int          errorCount;

    cpuTop cpuTop_inst (
        .clk       (clk),
        .reset     (reset),
        .stop      (stop),
        .run       (run),
        .inPort    (inPort),
        .outPort   (outPort),
        .loadWrite (loadWrite),
        .loadAddr  (loadAddr),
        .loadData  (loadData)
    );

    always #10 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic stepLfsr();
        logic feedback;
        feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};
        return feedback;
    endfunction

    function automatic dataWord randomBits(input int count);
        dataWord value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], stepLfsr()};
        end
        return value;
    endfunction

    function automatic dataWord signExtend(input logic [18:0] c);
        return {{13{c[18]}}, c};
    endfunction

    // instruction assembly
    function automatic dataWord encodeReg(input opcode op, input regIndex ra,
                                          input regIndex rb, input regIndex rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    function automatic dataWord encodeImm(input opcode op, input regIndex ra,
                                          input regIndex rb, input logic [18:0] c);
        return {op, ra, rb, c};
    endfunction

    function automatic dataWord expectAlu(input opcode op, input dataWord a, input dataWord b);
        case (op)
            opAdd, opAddi: return a + b;
            opSub:         return a - b;
            opAnd, opAndi: return a & b;
            opOr, opOri:   return a | b;
            opShr:         return a >> b[4:0];
            opShl:         return a << b[4:0];
            default:       return '0;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [1:0] cond, input dataWord value);
        case (cond)
            2'b00:   return value == '0;
            2'b01:   return value != '0;
            2'b10:   return !value[31];
            default: return value[31];
        endcase
    endfunction

    task automatic checkWord(input string name, input dataWord expected, input dataWord actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkRun(input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH at %0t: run expected %b, got %b", $time, expected, actual);
        end
    endtask

    task automatic resetCpu();
        @(posedge clk);
        reset <= 1'b1;
        stop <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic loadWord(input memAddr addr, input dataWord data);
        @(posedge clk);
        loadWrite <= 1'b1;
        loadAddr <= addr;
        loadData <= data;
        @(posedge clk);
        loadWrite <= 1'b0;
    endtask

    // program goes in while stop holds the sequencer at T0
    task automatic startProgram();
        resetCpu();
        foreach (prog[i]) begin
            loadWord(memAddr'(i), prog[i]);
        end
        @(posedge clk);
        stop <= 1'b0;
    endtask

    task automatic waitHalt();
        @(negedge clk);
        while (run) begin
            @(negedge clk);
        end
    endtask

    task automatic finishProgram(input regIndex outReg);
        prog.push_back(encodeImm(opOut, outReg, 4'd0, '0));
        prog.push_back(encodeImm(opHalt, 4'd0, 4'd0, '0));
    endtask

    task automatic runAndCheck(input dataWord expected);
        startProgram();
        waitHalt();
        checkWord("outPort", expected, outPort);
        // run stays low after the halt
        @(negedge clk);
        checkRun(1'b0, run);
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    task automatic testRegAlu();
        opcode   ops [4];
        dataWord a;
        dataWord b;
        int      errorsBefore;
        errorsBefore = errorCount;
        ops = '{opAdd, opSub, opAnd, opOr};
        repeat (6) begin
            a = randomBits(16);
            b = randomBits(16);
            foreach (ops[k]) begin
                prog = {};
                prog.push_back(encodeImm(opLdi, 4'd1, 4'd0, a[18:0]));
                prog.push_back(encodeImm(opLdi, 4'd2, 4'd0, b[18:0]));
                prog.push_back(encodeReg(ops[k], 4'd3, 4'd1, 4'd2));
                finishProgram(4'd3);
                runAndCheck(expectAlu(ops[k], a, b));
            end
        end
        reportTest("ldi and register ALU", errorsBefore);
    endtask

    task automatic testImmShift();
        opcode   immOps [3];
        opcode   shiftOps [2];
        dataWord a;
        dataWord imm;
        dataWord count;
        int      errorsBefore;
        errorsBefore = errorCount;
        immOps = '{opAddi, opAndi, opOri};
        shiftOps = '{opShr, opShl};
        repeat (3) begin
            a = randomBits(19);
            imm = randomBits(19);
            count = randomBits(5);
            foreach (immOps[k]) begin
                prog = {};
                prog.push_back(encodeImm(opLdi, 4'd1, 4'd0, a[18:0]));
                prog.push_back(encodeImm(immOps[k], 4'd2, 4'd1, imm[18:0]));
                finishProgram(4'd2);
                runAndCheck(expectAlu(immOps[k], signExtend(a[18:0]), signExtend(imm[18:0])));
            end
            // shift count sits in R2
            foreach (shiftOps[k]) begin
                prog = {};
                prog.push_back(encodeImm(opLdi, 4'd1, 4'd0, a[18:0]));
                prog.push_back(encodeImm(opLdi, 4'd2, 4'd0, count[18:0]));
                prog.push_back(encodeReg(shiftOps[k], 4'd3, 4'd1, 4'd2));
                finishProgram(4'd3);
                runAndCheck(expectAlu(shiftOps[k], signExtend(a[18:0]), count));
            end
        end
        reportTest("immediate ALU and shifts", errorsBefore);
    endtask

    task automatic testLoadStore();
        dataWord value;
        dataWord tmp;
        memAddr  base;
        memAddr  offset;
        memAddr  addr;
        int      errorsBefore;
        errorsBefore = errorCount;
        repeat (3) begin
            value = randomBits(19);
            tmp = randomBits(6);
            base = {3'b100, tmp[5:0]};
            tmp = randomBits(4);
            offset = {5'd0, tmp[3:0]};
            addr = base + offset;
            prog = {};
            prog.push_back(encodeImm(opLdi, 4'd1, 4'd0, value[18:0]));
            prog.push_back(encodeImm(opLdi, 4'd2, 4'd0, {10'd0, base}));
            prog.push_back(encodeImm(opSt, 4'd1, 4'd2, {10'd0, offset}));
            prog.push_back(encodeImm(opLd, 4'd3, 4'd2, {10'd0, offset}));
            finishProgram(4'd3);
            runAndCheck(signExtend(value[18:0]));
            // R0 holds 7 and a wrong base would hit the decoy word
            loadWord(addr + 9'd7, ~signExtend(value[18:0]));
            prog = {};
            prog.push_back(encodeImm(opLdi, 4'd0, 4'd0, 19'd7));
            prog.push_back(encodeImm(opLd, 4'd4, 4'd0, {10'd0, addr}));
            finishProgram(4'd4);
            runAndCheck(signExtend(value[18:0]));
        end
        reportTest("store and load", errorsBefore);
    endtask

    task automatic testBranch();
        dataWord    n;
        dataWord    sum;
        dataWord    value;
        dataWord    tmp;
        logic [1:0] cond;
        int         errorsBefore;
        errorsBefore = errorCount;
        n = randomBits(3) + 32'd1;
        sum = '0;
        for (int i = 1; i <= int'(n); i++) begin
            sum = sum + dataWord'(i);
        end
        // loop body at 1..3 with a branch back by 3 from the incremented PC
        prog = {};
        prog.push_back(encodeImm(opLdi, 4'd1, 4'd0, n[18:0]));
        prog.push_back(encodeReg(opAdd, 4'd2, 4'd2, 4'd1));
        prog.push_back(encodeImm(opAddi, 4'd1, 4'd1, 19'h7ffff));
        prog.push_back(encodeImm(opBr, 4'd1, 4'b0001, 19'h7fffd));
        finishProgram(4'd2);
        runAndCheck(sum);
        for (int c = 0; c < 4; c++) begin
            cond = c[1:0];
            for (int v = 0; v < 3; v++) begin
                tmp = randomBits(18);
                case (v)
                    0:       value = '0;
                    1:       value = {14'd0, tmp[17:0]} | 32'd1;
                    default: value = signExtend({1'b1, tmp[17:0]});
                endcase
                // taken path outputs 55 and fall through outputs aa
                prog = {};
                prog.push_back(encodeImm(opLdi, 4'd1, 4'd0, value[18:0]));
                prog.push_back(encodeImm(opBr, 4'd1, {2'b00, cond}, 19'd3));
                prog.push_back(encodeImm(opLdi, 4'd2, 4'd0, 19'h000aa));
                finishProgram(4'd2);
                prog.push_back(encodeImm(opLdi, 4'd2, 4'd0, 19'h00055));
                finishProgram(4'd2);
                runAndCheck(branchTaken(cond, value) ? 32'h55 : 32'haa);
            end
        end
        reportTest("conditional branch", errorsBefore);
    endtask

    task automatic testPortsStop();
        dataWord inValue;
        dataWord mark;
        int      errorsBefore;
        errorsBefore = errorCount;
        inValue = randomBits(32);
        mark = randomBits(18);
        prog = {};
        prog.push_back(encodeImm(opIn, 4'd1, 4'd0, '0));
        prog.push_back(encodeImm(opOut, 4'd1, 4'd0, '0));
        prog.push_back(encodeImm(opLdi, 4'd2, 4'd0, mark[18:0]));
        finishProgram(4'd2);
        @(posedge clk);
        inPort <= inValue;
        startProgram();
        @(negedge clk);
        checkRun(1'b1, run);
        checkWord("outPort", '0, outPort);
        while (outPort !== inValue) begin
            @(negedge clk);
        end
        // the ldi still runs before the sequencer parks at T0
        @(posedge clk);
        stop <= 1'b1;
        repeat (30) begin
            @(negedge clk);
            checkRun(1'b1, run);
            checkWord("outPort", inValue, outPort);
        end
        @(posedge clk);
        stop <= 1'b0;
        waitHalt();
        checkWord("outPort", signExtend(mark[18:0]), outPort);
        repeat (10) begin
            @(negedge clk);
            checkRun(1'b0, run);
        end
        reportTest("ports, stop and halt", errorsBefore);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        stop = 1'b1;
        inPort = '0;
        loadWrite = 1'b0;
        loadAddr = '0;
        loadData = '0;
        lfsrState = 32'h70f;
        checkCount = 0;
        errorCount = 0;
        testRegAlu();
        testImmShift();
        testLoadStore();
        testBranch();
        testPortsStop();
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        repeat (numTests * cyclesPerTest) @(posedge clk);
        $display("watchdog expired after %0d cycles, the CPU never halted",
                 numTests * cyclesPerTest);
        $display("tests failed");
        $finish;
    end

endmodule

// File: cpuTop.f
rtl/cpuPkg.sv
rtl/aluUnit.sv
rtl/registerFile.sv
rtl/dataPath.sv
rtl/controlUnit.sv
rtl/memory512x32.sv
rtl/cpuTop.sv
dv/cpuTopTb.sv

// File: Makefile
# Verilator build and run of the cpuTop testbench

run: obj_dir/VcpuTopTb
	./obj_dir/VcpuTopTb > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "tests failed" sim.log; then exit 1; fi
	@grep -q "all tests passed" sim.log

obj_dir/VcpuTopTb: cpuTop.f $(wildcard rtl/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module cpuTopTb -f cpuTop.f

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
